// File: design/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  // ==========================================================================
  // Base opcodes.
  // ==========================================================================
  localparam logic [6:0] opcode_lui       = 7'b0110111;
  localparam logic [6:0] opcode_auipc     = 7'b0010111;
  localparam logic [6:0] opcode_jal       = 7'b1101111;
  localparam logic [6:0] opcode_jalr      = 7'b1100111;
  localparam logic [6:0] opcode_branch    = 7'b1100011;
  localparam logic [6:0] opcode_load      = 7'b0000011;
  localparam logic [6:0] opcode_store     = 7'b0100011;
  localparam logic [6:0] opcode_immediate = 7'b0010011;
  localparam logic [6:0] opcode_register  = 7'b0110011;
  localparam logic [6:0] opcode_fence     = 7'b0001111;
  localparam logic [6:0] opcode_system    = 7'b1110011;

  // ALU funct3 values.
  localparam logic [2:0] funct_add  = 3'b000;
  localparam logic [2:0] funct_sll  = 3'b001;
  localparam logic [2:0] funct_slt  = 3'b010;
  localparam logic [2:0] funct_sltu = 3'b011;
  localparam logic [2:0] funct_xor  = 3'b100;
  localparam logic [2:0] funct_srl  = 3'b101;
  localparam logic [2:0] funct_or   = 3'b110;
  localparam logic [2:0] funct_and  = 3'b111;

  // Second variant selects sub and sra.
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  // addi x0, x0, 0.
  localparam logic [31:0] nop_instr = 32'h0000_0013;

  // ==========================================================================
  // One instruction word, seen as R-type or I-type.
  // ==========================================================================
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } rtype;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } itype;
  } instr_word_t;

endpackage

`default_nettype wire

// File: design/issue_pkg.sv
`default_nettype none

package issue_pkg;

  // ==========================================================================
  // Fetch queue geometry.
  // ==========================================================================
  localparam int unsigned queue_depth       = 8;
  localparam int unsigned queue_index_width = 3;
  localparam int unsigned queue_count_width = 4;

  // Full leaves room for one more two-word strobe.
  localparam int unsigned full_threshold = 4;

  // Issue class of one instruction.
  typedef enum logic {
    class_basic   = 1'b0,
    class_complex = 1'b1
  } issue_class_t;

endpackage

`default_nettype wire

// File: design/fetch_queue.sv
`default_nettype none

module fetch_queue (
  input  logic        clock,
  input  logic        reset,
  input  logic        flush,
  input  logic        fetch_valid,
  input  logic [31:0] fetch_pc,
  input  logic [63:0] fetch_data,
  input  logic [1:0]  issue_count,
  output logic        fetch_full,
  output logic        head0_valid,
  output logic [31:0] head0_pc,
  output logic [31:0] head0_instr,
  output logic        head1_valid,
  output logic [31:0] head1_pc,
  output logic [31:0] head1_instr
);

  logic [31:0] pc_mem    [issue_pkg::queue_depth];
  logic [31:0] instr_mem [issue_pkg::queue_depth];

  logic [issue_pkg::queue_index_width-1:0] wr_ptr;
  logic [issue_pkg::queue_index_width-1:0] rd_ptr;
  logic [issue_pkg::queue_index_width-1:0] wr_ptr1;
  logic [issue_pkg::queue_index_width-1:0] rd_ptr1;
  logic [issue_pkg::queue_index_width-1:0] index_one;

  logic [issue_pkg::queue_count_width-1:0] count;
  logic [issue_pkg::queue_count_width-1:0] count_next;
  logic [issue_pkg::queue_count_width-1:0] count_two;
  logic [issue_pkg::queue_count_width-1:0] retire_count;

  logic accept;

  assign index_one    = {{(issue_pkg::queue_index_width-1){1'b0}}, 1'b1};
  assign count_two    = {{(issue_pkg::queue_count_width-2){1'b0}}, 2'd2};
  assign retire_count = {{(issue_pkg::queue_count_width-2){1'b0}}, issue_count};

  assign wr_ptr1 = wr_ptr + index_one;
  assign rd_ptr1 = rd_ptr + index_one;

  // A strobe while full is dropped.
  assign accept = fetch_valid && !fetch_full && !flush;

  assign count_next = count + (accept ? count_two : '0) - retire_count;

  // ==========================================================================
  // Entry storage.
  // ==========================================================================
  always_ff @(posedge clock) begin
    if (accept) begin
      pc_mem[wr_ptr]     <= fetch_pc;
      instr_mem[wr_ptr]  <= fetch_data[31:0];
      pc_mem[wr_ptr1]    <= fetch_pc + 32'd4;
      instr_mem[wr_ptr1] <= fetch_data[63:32];
    end
  end

  // ==========================================================================
  // Pointers, occupancy and full flag.
  // ==========================================================================
  always_ff @(posedge clock) begin
    if (!reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      fetch_full <= 1'b0;
    end else if (flush) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      fetch_full <= 1'b0;
    end else begin
      if (accept) begin
        wr_ptr <= wr_ptr1 + index_one;
      end
      rd_ptr     <= rd_ptr + retire_count[issue_pkg::queue_index_width-1:0];
      count      <= count_next;
      fetch_full <= (count_next > issue_pkg::full_threshold);
    end
  end

  // Oldest two entries.
  assign head0_valid = (count != '0);
  assign head1_valid = (count >= count_two);

  assign head0_pc    = head0_valid ? pc_mem[rd_ptr] : 32'd0;
  assign head0_instr = head0_valid ? instr_mem[rd_ptr] : riscv_pkg::nop_instr;
  assign head1_pc    = head1_valid ? pc_mem[rd_ptr1] : 32'd0;
  assign head1_instr = head1_valid ? instr_mem[rd_ptr1] : riscv_pkg::nop_instr;

endmodule

`default_nettype wire

// File: design/instr_classify.sv
`default_nettype none

module instr_classify (
  input  riscv_pkg::instr_word_t  instr,
  output issue_pkg::issue_class_t instr_class,
  output logic                    wren,
  output logic                    rden1,
  output logic                    rden2,
  output logic [4:0]              waddr,
  output logic [4:0]              raddr1,
  output logic [4:0]              raddr2
);

  logic       write_sel;
  logic [6:0] shift_funct7;

  // Shift-immediate qualifier sits in the upper immediate bits.
  assign shift_funct7 = instr.itype.imm[11:5];

  assign waddr  = instr.rtype.rd;
  assign raddr1 = instr.rtype.rs1;
  assign raddr2 = instr.rtype.rs2;

  // No register write for rd x0.
  assign wren = write_sel && (instr.rtype.rd != 5'd0);

  always_comb begin
    instr_class = issue_pkg::class_complex;
    write_sel   = 1'b0;
    rden1       = 1'b0;
    rden2       = 1'b0;

    case (instr.rtype.opcode)
      riscv_pkg::opcode_lui, riscv_pkg::opcode_auipc, riscv_pkg::opcode_jal: begin
        instr_class = issue_pkg::class_basic;
        write_sel   = 1'b1;
      end
      riscv_pkg::opcode_jalr: begin
        instr_class = issue_pkg::class_basic;
        write_sel   = 1'b1;
        rden1       = 1'b1;
      end
      riscv_pkg::opcode_branch, riscv_pkg::opcode_store: begin
        rden1 = 1'b1;
        rden2 = 1'b1;
      end
      riscv_pkg::opcode_load: begin
        write_sel = 1'b1;
        rden1     = 1'b1;
      end
      riscv_pkg::opcode_immediate: begin
        write_sel = 1'b1;
        rden1     = 1'b1;
        case (instr.itype.funct3)
          riscv_pkg::funct_add, riscv_pkg::funct_slt, riscv_pkg::funct_sltu,
          riscv_pkg::funct_and, riscv_pkg::funct_or, riscv_pkg::funct_xor: begin
            instr_class = issue_pkg::class_basic;
          end
          riscv_pkg::funct_sll: begin
            if (shift_funct7 == riscv_pkg::funct7_base) begin
              instr_class = issue_pkg::class_basic;
            end
          end
          riscv_pkg::funct_srl: begin
            if (shift_funct7 == riscv_pkg::funct7_base ||
                shift_funct7 == riscv_pkg::funct7_alt) begin
              instr_class = issue_pkg::class_basic;
            end
          end
          default: begin
          end
        endcase
      end
      riscv_pkg::opcode_register: begin
        write_sel = 1'b1;
        rden1     = 1'b1;
        rden2     = 1'b1;
        if (instr.rtype.funct7 == riscv_pkg::funct7_base) begin
          instr_class = issue_pkg::class_basic;
        end else if (instr.rtype.funct7 == riscv_pkg::funct7_alt &&
                     (instr.rtype.funct3 == riscv_pkg::funct_add ||
                      instr.rtype.funct3 == riscv_pkg::funct_srl)) begin
          instr_class = issue_pkg::class_basic;
        end
      end
      riscv_pkg::opcode_fence: begin
        // Ordering only.
        write_sel = 1'b0;
      end
      riscv_pkg::opcode_system: begin
        // CSR ops; funct3 1 to 3 take rs1, the rest an immediate.
        write_sel = (instr.itype.funct3 != 3'd0);
        rden1     = (instr.itype.funct3 != 3'd0) && !instr.itype.funct3[2];
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/pair_select.sv
`default_nettype none

module pair_select (
  input  logic                    hold,
  input  logic                    head0_valid,
  input  logic [31:0]             head0_pc,
  input  logic [31:0]             head0_instr,
  input  logic                    head1_valid,
  input  logic [31:0]             head1_pc,
  input  logic [31:0]             head1_instr,
  input  issue_pkg::issue_class_t class0,
  input  logic                    wren0,
  input  logic [4:0]              waddr0,
  input  issue_pkg::issue_class_t class1,
  input  logic                    rden1_1,
  input  logic                    rden2_1,
  input  logic [4:0]              raddr1_1,
  input  logic [4:0]              raddr2_1,
  output logic [1:0]              issue_count,
  output logic                    issue_swap,
  output logic [31:0]             lane0_pc,
  output logic [31:0]             lane0_npc,
  output logic [31:0]             lane0_instr,
  output logic [31:0]             lane1_pc,
  output logic [31:0]             lane1_npc,
  output logic [31:0]             lane1_instr
);

  logic        raw_hazard;
  logic        both_complex;
  logic [31:0] head0_npc;
  logic [31:0] head1_npc;

  // Head 1 reads what head 0 writes.
  assign raw_hazard = wren0 &&
                      ((rden1_1 && raddr1_1 == waddr0) ||
                       (rden2_1 && raddr2_1 == waddr0));

  assign both_complex = (class0 == issue_pkg::class_complex) &&
                        (class1 == issue_pkg::class_complex);

  // ==========================================================================
  // Pairing decision.
  // ==========================================================================
  always_comb begin
    if (hold || !head0_valid) begin
      issue_count = 2'd0;
    end else if (!head1_valid || both_complex || raw_hazard) begin
      issue_count = 2'd1;
    end else begin
      issue_count = 2'd2;
    end
  end

  // Complex op goes to lane 0.
  assign issue_swap = (issue_count == 2'd2) &&
                      (class0 == issue_pkg::class_basic) &&
                      (class1 == issue_pkg::class_complex);

  // Compressed encodings step by two.
  assign head0_npc = head0_pc + ((head0_instr[1:0] == 2'b11) ? 32'd4 : 32'd2);
  assign head1_npc = head1_pc + ((head1_instr[1:0] == 2'b11) ? 32'd4 : 32'd2);

  // ==========================================================================
  // Lane outputs.
  // ==========================================================================
  always_comb begin
    lane0_pc    = 32'd0;
    lane0_npc   = 32'd0;
    lane0_instr = riscv_pkg::nop_instr;
    lane1_pc    = 32'd0;
    lane1_npc   = 32'd0;
    lane1_instr = riscv_pkg::nop_instr;
    if (issue_swap) begin
      lane0_pc    = head1_pc;
      lane0_npc   = head1_npc;
      lane0_instr = head1_instr;
      lane1_pc    = head0_pc;
      lane1_npc   = head0_npc;
      lane1_instr = head0_instr;
    end else begin
      if (issue_count != 2'd0) begin
        lane0_pc    = head0_pc;
        lane0_npc   = head0_npc;
        lane0_instr = head0_instr;
      end
      if (issue_count == 2'd2) begin
        lane1_pc    = head1_pc;
        lane1_npc   = head1_npc;
        lane1_instr = head1_instr;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/issue_top.sv
`default_nettype none

module issue_top (
  input  logic        clock,
  input  logic        reset,
  input  logic        fetch_valid,
  input  logic [31:0] fetch_pc,
  input  logic [63:0] fetch_data,
  input  logic        flush,
  input  logic        hold,
  output logic        fetch_full,
  output logic [1:0]  issue_count,
  output logic        issue_swap,
  output logic [31:0] lane0_pc,
  output logic [31:0] lane0_npc,
  output logic [31:0] lane0_instr,
  output logic [31:0] lane1_pc,
  output logic [31:0] lane1_npc,
  output logic [31:0] lane1_instr
);

  logic        head0_valid;
  logic [31:0] head0_pc;
  logic [31:0] head0_instr;
  logic        head1_valid;
  logic [31:0] head1_pc;
  logic [31:0] head1_instr;

  issue_pkg::issue_class_t class0;
  issue_pkg::issue_class_t class1;

  logic       wren0;
  logic [4:0] waddr0;
  logic       rden1_1;
  logic       rden2_1;
  logic [4:0] raddr1_1;
  logic [4:0] raddr2_1;

  fetch_queue queue (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_data  (fetch_data),
    .issue_count (issue_count),
    .fetch_full  (fetch_full),
    .head0_valid (head0_valid),
    .head0_pc    (head0_pc),
    .head0_instr (head0_instr),
    .head1_valid (head1_valid),
    .head1_pc    (head1_pc),
    .head1_instr (head1_instr)
  );

  // Slot 0 only writes, slot 1 only reads, for the hazard check.
  instr_classify slot0 (
    .instr       (head0_instr),
    .instr_class (class0),
    .wren        (wren0),
    .rden1       (),
    .rden2       (),
    .waddr       (waddr0),
    .raddr1      (),
    .raddr2      ()
  );

  instr_classify slot1 (
    .instr       (head1_instr),
    .instr_class (class1),
    .wren        (),
    .rden1       (rden1_1),
    .rden2       (rden2_1),
    .waddr       (),
    .raddr1      (raddr1_1),
    .raddr2      (raddr2_1)
  );

  pair_select select (
    .hold        (hold),
    .head0_valid (head0_valid),
    .head0_pc    (head0_pc),
    .head0_instr (head0_instr),
    .head1_valid (head1_valid),
    .head1_pc    (head1_pc),
    .head1_instr (head1_instr),
    .class0      (class0),
    .wren0       (wren0),
    .waddr0      (waddr0),
    .class1      (class1),
    .rden1_1     (rden1_1),
    .rden2_1     (rden2_1),
    .raddr1_1    (raddr1_1),
    .raddr2_1    (raddr2_1),
    .issue_count (issue_count),
    .issue_swap  (issue_swap),
    .lane0_pc    (lane0_pc),
    .lane0_npc   (lane0_npc),
    .lane0_instr (lane0_instr),
    .lane1_pc    (lane1_pc),
    .lane1_npc   (lane1_npc),
    .lane1_instr (lane1_instr)
  );

endmodule

`default_nettype wire

// File: tb/issue_top_tb.sv
`default_nettype none

module issue_top_tb;

  localparam int num_rows       = 22;
  localparam int timeout_cycles = (num_rows + 20) * 2;
  localparam int half_period    = 5;

  // Instruction words used by the table.
  localparam logic [31:0] nop          = riscv_pkg::nop_instr;
  localparam logic [31:0] addi_x1_5    = 32'h0050_0093;
  localparam logic [31:0] add_x3_x4_x5 = 32'h0052_01b3;
  localparam logic [31:0] add_x2_x1_x1 = 32'h0010_8133;
  localparam logic [31:0] addi_x0_1    = 32'h0010_0013;
  localparam logic [31:0] add_x6_x0_x0 = 32'h0000_0333;
  localparam logic [31:0] lw_x7_x8     = 32'h0004_2383;
  localparam logic [31:0] sw_x9_x10    = 32'h0095_2223;
  localparam logic [31:0] short_word   = 32'h0000_0001;

  localparam logic [63:0] pair_indep = {add_x3_x4_x5, addi_x1_5};

  logic        clock;
  logic        reset;
  logic        fetch_valid;
  logic [31:0] fetch_pc;
  logic [63:0] fetch_data;
  logic        flush;
  logic        hold;
  logic        fetch_full;
  logic [1:0]  issue_count;
  logic        issue_swap;
  logic [31:0] lane0_pc;
  logic [31:0] lane0_npc;
  logic [31:0] lane0_instr;
  logic [31:0] lane1_pc;
  logic [31:0] lane1_npc;
  logic [31:0] lane1_instr;

  // Stimulus and expected values, one entry per cycle.
  logic        row_fetch_valid [num_rows];
  logic [31:0] row_fetch_pc    [num_rows];
  logic [63:0] row_fetch_data  [num_rows];
  logic        row_flush       [num_rows];
  logic        row_hold        [num_rows];
  logic [1:0]  row_count       [num_rows];
  logic        row_swap        [num_rows];
  logic [31:0] row_lane0_pc    [num_rows];
  logic [31:0] row_lane0_instr [num_rows];
  logic [31:0] row_lane1_pc    [num_rows];
  logic [31:0] row_lane1_instr [num_rows];
  logic [31:0] row_lane0_npc   [num_rows];
  logic [31:0] row_lane1_npc   [num_rows];
  logic        row_full        [num_rows];

  int row_total;
  int cycle_count;

  issue_top dut (
    .clock       (clock),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_data  (fetch_data),
    .flush       (flush),
    .hold        (hold),
    .fetch_full  (fetch_full),
    .issue_count (issue_count),
    .issue_swap  (issue_swap),
    .lane0_pc    (lane0_pc),
    .lane0_npc   (lane0_npc),
    .lane0_instr (lane0_instr),
    .lane1_pc    (lane1_pc),
    .lane1_npc   (lane1_npc),
    .lane1_instr (lane1_instr)
  );

  initial begin
    clock = 1'b0;
    forever #(half_period) clock = ~clock;
  end

  // ==========================================================================
  // Helpers.
  // ==========================================================================
  task automatic add_row(input logic fv, input logic [31:0] pc, input logic [63:0] data,
                         input logic fl, input logic hd, input logic [1:0] cnt,
                         input logic swp, input logic [31:0] pc0, input logic [31:0] in0,
                         input logic [31:0] pc1, input logic [31:0] in1,
                         input logic [31:0] npc0, input logic [31:0] npc1,
                         input logic full);
    row_fetch_valid[row_total] = fv;
    row_fetch_pc[row_total]    = pc;
    row_fetch_data[row_total]  = data;
    row_flush[row_total]       = fl;
    row_hold[row_total]        = hd;
    row_count[row_total]       = cnt;
    row_swap[row_total]        = swp;
    row_lane0_pc[row_total]    = pc0;
    row_lane0_instr[row_total] = in0;
    row_lane1_pc[row_total]    = pc1;
    row_lane1_instr[row_total] = in1;
    row_lane0_npc[row_total]   = npc0;
    row_lane1_npc[row_total]   = npc1;
    row_full[row_total]        = full;
    row_total = row_total + 1;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic build_table();
    row_total = 0;
    // Reset state, then an independent pair.
    add_row(1'b0, 32'h0, 64'h0, 1'b0, 1'b0,
            2'd0, 1'b0, 32'h0, nop, 32'h0, nop, 32'h0, 32'h0, 1'b0);
    add_row(1'b1, 32'h100, pair_indep, 1'b0, 1'b0,
            2'd0, 1'b0, 32'h0, nop, 32'h0, nop, 32'h0, 32'h0, 1'b0);
    add_row(1'b1, 32'h200, {add_x2_x1_x1, addi_x1_5}, 1'b0, 1'b0,
            2'd2, 1'b0, 32'h100, addi_x1_5, 32'h104, add_x3_x4_x5, 32'h104, 32'h108, 1'b0);
    // Dependent pair splits over two cycles.
    add_row(1'b0, 32'h0, 64'h0, 1'b0, 1'b0,
            2'd1, 1'b0, 32'h200, addi_x1_5, 32'h0, nop, 32'h204, 32'h0, 1'b0);
    add_row(1'b1, 32'h300, {add_x6_x0_x0, addi_x0_1}, 1'b0, 1'b0,
            2'd1, 1'b0, 32'h204, add_x2_x1_x1, 32'h0, nop, 32'h208, 32'h0, 1'b0);
    // x0 carries no dependency.
    add_row(1'b1, 32'h400, {lw_x7_x8, addi_x1_5}, 1'b0, 1'b0,
            2'd2, 1'b0, 32'h300, addi_x0_1, 32'h304, add_x6_x0_x0, 32'h304, 32'h308, 1'b0);
    // Basic then load swaps lanes.
    add_row(1'b1, 32'h500, {sw_x9_x10, lw_x7_x8}, 1'b0, 1'b0,
            2'd2, 1'b1, 32'h404, lw_x7_x8, 32'h400, addi_x1_5, 32'h408, 32'h404, 1'b0);
    add_row(1'b0, 32'h0, 64'h0, 1'b0, 1'b0,
            2'd1, 1'b0, 32'h500, lw_x7_x8, 32'h0, nop, 32'h504, 32'h0, 1'b0);
    add_row(1'b0, 32'h0, 64'h0, 1'b0, 1'b0,
            2'd1, 1'b0, 32'h504, sw_x9_x10, 32'h0, nop, 32'h508, 32'h0, 1'b0);
    // ========================================================================
    // Hold fills the queue, the fourth strobe is dropped, then drain.
    // ========================================================================
    add_row(1'b1, 32'h600, pair_indep, 1'b0, 1'b1,
            2'd0, 1'b0, 32'h0, nop, 32'h0, nop, 32'h0, 32'h0, 1'b0);
    add_row(1'b1, 32'h700, pair_indep, 1'b0, 1'b1,
            2'd0, 1'b0, 32'h0, nop, 32'h0, nop, 32'h0, 32'h0, 1'b0);
    add_row(1'b1, 32'h800, pair_indep, 1'b0, 1'b1,
            2'd0, 1'b0, 32'h0, nop, 32'h0, nop, 32'h0, 32'h0, 1'b0);
    add_row(1'b1, 32'h900, pair_indep, 1'b0, 1'b1,
            2'd0, 1'b0, 32'h0, nop, 32'h0, nop, 32'h0, 32'h0, 1'b1);
    add_row(1'b0, 32'h0, 64'h0, 1'b0, 1'b0,
            2'd2, 1'b0, 32'h600, addi_x1_5, 32'h604, add_x3_x4_x5, 32'h604, 32'h608, 1'b1);
    add_row(1'b0, 32'h0, 64'h0, 1'b0, 1'b0,
            2'd2, 1'b0, 32'h700, addi_x1_5, 32'h704, add_x3_x4_x5, 32'h704, 32'h708, 1'b0);
    add_row(1'b0, 32'h0, 64'h0, 1'b0, 1'b0,
            2'd2, 1'b0, 32'h800, addi_x1_5, 32'h804, add_x3_x4_x5, 32'h804, 32'h808, 1'b0);
    // Refill, then flush while full.
    add_row(1'b1, 32'ha00, pair_indep, 1'b0, 1'b1,
            2'd0, 1'b0, 32'h0, nop, 32'h0, nop, 32'h0, 32'h0, 1'b0);
    add_row(1'b1, 32'hb00, pair_indep, 1'b0, 1'b1,
            2'd0, 1'b0, 32'h0, nop, 32'h0, nop, 32'h0, 32'h0, 1'b0);
    add_row(1'b1, 32'hc00, pair_indep, 1'b0, 1'b1,
            2'd0, 1'b0, 32'h0, nop, 32'h0, nop, 32'h0, 32'h0, 1'b0);
    add_row(1'b0, 32'h0, 64'h0, 1'b1, 1'b0,
            2'd2, 1'b0, 32'ha00, addi_x1_5, 32'ha04, add_x3_x4_x5, 32'ha04, 32'ha08, 1'b1);
    add_row(1'b1, 32'he00, {addi_x1_5, short_word}, 1'b0, 1'b0,
            2'd0, 1'b0, 32'h0, nop, 32'h0, nop, 32'h0, 32'h0, 1'b0);
    // Compressed head steps by two.
    add_row(1'b0, 32'h0, 64'h0, 1'b0, 1'b0,
            2'd2, 1'b0, 32'he00, short_word, 32'he04, addi_x1_5, 32'he02, 32'he08, 1'b0);
  endtask

  // ==========================================================================
  // Main sequence.
  // ==========================================================================
  initial begin
    reset       = 1'b0;
    fetch_valid = 1'b0;
    fetch_pc    = 32'd0;
    fetch_data  = 64'd0;
    flush       = 1'b0;
    hold        = 1'b0;
    build_table();

    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;

    for (int i = 0; i < num_rows; i++) begin
      fetch_valid = row_fetch_valid[i];
      fetch_pc    = row_fetch_pc[i];
      fetch_data  = row_fetch_data[i];
      flush       = row_flush[i];
      hold        = row_hold[i];
      // Sample just ahead of the rising edge.
      #(half_period - 1);
      check_value("issue_count", row_count[i], issue_count);
      check_value("issue_swap", row_swap[i], issue_swap);
      check_value("lane0_pc", row_lane0_pc[i], lane0_pc);
      check_value("lane0_instr", row_lane0_instr[i], lane0_instr);
      check_value("lane1_pc", row_lane1_pc[i], lane1_pc);
      check_value("lane1_instr", row_lane1_instr[i], lane1_instr);
      check_value("lane0_npc", row_lane0_npc[i], lane0_npc);
      check_value("lane1_npc", row_lane1_npc[i], lane1_npc);
      check_value("fetch_full", row_full[i], fetch_full);
      @(negedge clock);
    end

    fetch_valid = 1'b0;
    flush       = 1'b0;
    hold        = 1'b0;
    $display("NO ERRORS");
    $finish;
  end

  // Watchdog on the cycle count.
  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clock);
      cycle_count = cycle_count + 1;
    end
    $display("Timeout: the run hung and did not finish within %0d cycles", timeout_cycles);
    $display("ERRORS FOUND");
    $fatal(1);
  end

endmodule

`default_nettype wire

// File: issue_top.f
design/riscv_pkg.sv
design/issue_pkg.sv
design/fetch_queue.sv
design/instr_classify.sv
design/pair_select.sv
design/issue_top.sv
tb/issue_top_tb.sv

// File: Bender.yml
package:
  name: issue_top

sources:
  - files:
      - design/riscv_pkg.sv
      - design/issue_pkg.sv
      - design/fetch_queue.sv
      - design/instr_classify.sv
      - design/pair_select.sv
      - design/issue_top.sv
  - target: simulation
    files:
      - tb/issue_top_tb.sv
